// ==== rtl/opl_slot_pkg.sv ====
// shared sizes and field widths of the slot engine
// sequencer state enum
// channel to operator slot mapping helpers

package opl_slot_pkg;

    localparam int NUM_BANKS = 2;
    localparam int NUM_CHANNELS_PER_BANK = 9;
    localparam int NUM_OPERATORS_PER_BANK = 18;

    localparam int BANK_NUM_WIDTH = 1;
    localparam int OP_NUM_WIDTH = 5;

    localparam int FNUM_WIDTH = 10;  // frequency number
    localparam int BLOCK_WIDTH = 3;  // octave
    localparam int MULT_WIDTH = 4;
    localparam int FB_WIDTH = 3;
    localparam int PHASE_WIDTH = 19;
    localparam int OP_OUT_WIDTH = 13;  // signed sample

    typedef enum logic {
        SEQ_IDLE,
        SEQ_RUN
    } seq_state_t;

    // modulator slot of a channel in 2-operator mode
    function automatic logic [OP_NUM_WIDTH-1:0] mod_slot_of(input int ch);
        if (ch < 3) begin
            return OP_NUM_WIDTH'(ch);
        end else if (ch < 6) begin
            return OP_NUM_WIDTH'(ch + 3);
        end else begin
            return OP_NUM_WIDTH'(ch + 6);
        end
    endfunction

    // carrier sits three slots after its modulator
    function automatic logic [OP_NUM_WIDTH-1:0] car_slot_of(input int ch);
        return mod_slot_of(ch) + OP_NUM_WIDTH'(3);
    endfunction

endpackage

// ==== rtl/slot_if.sv ====
// slot_if carries the current slot index and start strobe from the sequencer
// op_param_if carries the routed operator parameters of the current slot
// op_result_if carries the tagged operator result

interface slot_if;
    logic slot_start;  // first cycle of a slot window
    logic [opl_slot_pkg::BANK_NUM_WIDTH-1:0] bank_num;
    logic [opl_slot_pkg::OP_NUM_WIDTH-1:0] op_num;
    logic busy;  // frame sweep in progress

    modport master (output slot_start, output bank_num, output op_num, output busy);
    modport monitor (input slot_start, input bank_num, input op_num);
    modport timer (input slot_start, input busy);
endinterface

interface op_param_if;
    logic [opl_slot_pkg::FNUM_WIDTH-1:0] fnum;
    logic [opl_slot_pkg::BLOCK_WIDTH-1:0] block;
    logic [opl_slot_pkg::MULT_WIDTH-1:0] mult;
    logic [opl_slot_pkg::FB_WIDTH-1:0] fb;
    logic use_feedback;
    logic signed [opl_slot_pkg::OP_OUT_WIDTH-1:0] modulation;

    modport source (output fnum, output block, output mult, output fb,
                    output use_feedback, output modulation);
    modport sink (input fnum, input block, input mult, input fb,
                  input use_feedback, input modulation);
endinterface

interface op_result_if;
    logic result_valid;  // one cycle per slot
    logic [opl_slot_pkg::BANK_NUM_WIDTH-1:0] result_bank;
    logic [opl_slot_pkg::OP_NUM_WIDTH-1:0] result_op;
    logic signed [opl_slot_pkg::OP_OUT_WIDTH-1:0] result;

    modport source (output result_valid, output result_bank, output result_op, output result);
    modport sink (input result_valid, input result_bank, input result_op, input result);
endinterface

// ==== rtl/slot_sequencer.sv ====
// frame state machine of the slot engine
// walks bank 0 ops 0-17 and then bank 1 ops 0-17 with one start strobe per slot

module slot_sequencer (
    input logic clk,
    input logic rst_n,
    input logic sample_clk_en,
    input logic slot_end,
    slot_if.master slot
);

    localparam int LAST_OP = opl_slot_pkg::NUM_OPERATORS_PER_BANK - 1;
    localparam int LAST_BANK = opl_slot_pkg::NUM_BANKS - 1;

    opl_slot_pkg::seq_state_t state;
    logic last_slot;

    assign last_slot = (slot.bank_num == opl_slot_pkg::BANK_NUM_WIDTH'(LAST_BANK)) &&
                       (slot.op_num == opl_slot_pkg::OP_NUM_WIDTH'(LAST_OP));

    assign slot.busy = (state == opl_slot_pkg::SEQ_RUN);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= opl_slot_pkg::SEQ_IDLE;
            slot.slot_start <= 1'b0;
            slot.bank_num <= '0;
            slot.op_num <= '0;
        end else begin
            slot.slot_start <= 1'b0;  // strobe by default
            case (state)
                opl_slot_pkg::SEQ_IDLE: begin
                    if (sample_clk_en) begin
                        state <= opl_slot_pkg::SEQ_RUN;
                        slot.slot_start <= 1'b1;
                        slot.bank_num <= '0;
                        slot.op_num <= '0;
                    end
                end
                opl_slot_pkg::SEQ_RUN: begin
                    if (slot_end) begin
                        if (last_slot) begin
                            state <= opl_slot_pkg::SEQ_IDLE;  // frame swept
                        end else begin
                            slot.slot_start <= 1'b1;
                            if (slot.op_num == opl_slot_pkg::OP_NUM_WIDTH'(LAST_OP)) begin
                                slot.op_num <= '0;
                                slot.bank_num <= slot.bank_num + 1'b1;
                            end else begin
                                slot.op_num <= slot.op_num + 1'b1;
                            end
                        end
                    end
                end
                default: state <= opl_slot_pkg::SEQ_IDLE;
            endcase
        end
    end

endmodule

// ==== rtl/slot_timer.sv ====
// slot window counter
// slot_end marks the last of PIPELINE_DELAY+1 cycles after slot_start

module slot_timer #(
    parameter int PIPELINE_DELAY = 6
) (
    input logic clk,
    input logic rst_n,
    slot_if.timer slot,
    output logic slot_end
);

    localparam int CNT_WIDTH = $clog2(PIPELINE_DELAY + 1);

    logic [CNT_WIDTH-1:0] count;  // cycles since slot_start

    assign slot_end = slot.busy && !slot.slot_start &&
                      (count == CNT_WIDTH'(PIPELINE_DELAY));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
        end else if (slot.slot_start) begin
            count <= CNT_WIDTH'(1);  // start cycle counts as zero
        end else if (slot.busy && !slot_end) begin
            count <= count + 1'b1;
        end else begin
            count <= '0;
        end
    end

endmodule

// ==== rtl/slot_router.sv ====
// per-slot parameter routing
// channel ownership, 4-operator pairs and self-feedback on the first operator

module slot_router (
    slot_if.monitor slot,
    input logic [opl_slot_pkg::NUM_BANKS*3-1:0] connection_sel,  // 3 pairs per bank
    input logic [opl_slot_pkg::FNUM_WIDTH-1:0] fnum
        [opl_slot_pkg::NUM_BANKS][opl_slot_pkg::NUM_CHANNELS_PER_BANK],
    input logic [opl_slot_pkg::BLOCK_WIDTH-1:0] block
        [opl_slot_pkg::NUM_BANKS][opl_slot_pkg::NUM_CHANNELS_PER_BANK],
    input logic [opl_slot_pkg::FB_WIDTH-1:0] fb
        [opl_slot_pkg::NUM_BANKS][opl_slot_pkg::NUM_CHANNELS_PER_BANK],
    input logic cnt [opl_slot_pkg::NUM_BANKS][opl_slot_pkg::NUM_CHANNELS_PER_BANK],
    input logic [opl_slot_pkg::MULT_WIDTH-1:0] mult
        [opl_slot_pkg::NUM_BANKS][opl_slot_pkg::NUM_OPERATORS_PER_BANK],
    input logic signed [opl_slot_pkg::OP_OUT_WIDTH-1:0] mod_sample,
    op_param_if.source params
);

    logic [3:0] owner;   // owning channel in 2-operator mode
    logic is_mod;        // first operator of its channel
    logic [1:0] pair;
    logic [1:0] pos;     // position inside a 4-operator chain
    logic four_op;

    // 2-operator ownership from the channel map
    always_comb begin
        owner = '0;
        is_mod = 1'b0;
        for (int c = 0; c < opl_slot_pkg::NUM_CHANNELS_PER_BANK; c++) begin
            if (slot.op_num == opl_slot_pkg::mod_slot_of(c)) begin
                owner = 4'(c);
                is_mod = 1'b1;
            end
            if (slot.op_num == opl_slot_pkg::car_slot_of(c)) begin
                owner = 4'(c);
            end
        end
    end

    // slots p, p+3, p+6, p+9 of pair p
    assign pair = 2'(slot.op_num % 3);
    assign pos = 2'(slot.op_num / 3);
    assign four_op = (slot.op_num < opl_slot_pkg::OP_NUM_WIDTH'(12)) &&
                     connection_sel[slot.bank_num * 3 + pair];

    assign params.mult = mult[slot.bank_num][slot.op_num];  // always per slot

    always_comb begin
        if (four_op) begin
            params.fnum = fnum[slot.bank_num][pair];
            params.block = block[slot.bank_num][pair];
            params.use_feedback = (pos == 2'd0);
            params.fb = (pos == 2'd0) ? fb[slot.bank_num][pair] : '0;
            case (pos)
                2'd0: params.modulation = '0;
                2'd1: params.modulation = cnt[slot.bank_num][pair] ? '0 : mod_sample;
                2'd2: params.modulation = (!cnt[slot.bank_num][pair] &&
                                           cnt[slot.bank_num][pair + 3]) ? '0 : mod_sample;
                default: params.modulation = (cnt[slot.bank_num][pair] &&
                                              cnt[slot.bank_num][pair + 3]) ? '0 : mod_sample;
            endcase
        end else begin
            params.fnum = fnum[slot.bank_num][owner];
            params.block = block[slot.bank_num][owner];
            params.use_feedback = is_mod;
            params.fb = is_mod ? fb[slot.bank_num][owner] : '0;
            // carrier is unmodulated in additive mode
            params.modulation = (is_mod || cnt[slot.bank_num][owner]) ? '0 : mod_sample;
        end
    end

endmodule

// ==== rtl/operator_core.sv ====
// shared operator pipeline with its result PIPELINE_DELAY cycles after slot_start
// per-slot phase accumulator and previous-output memories
// works for PIPELINE_DELAY of 3 or more

module operator_core #(
    parameter int PIPELINE_DELAY = 6
) (
    input logic clk,
    input logic rst_n,
    slot_if.monitor slot,
    op_param_if.sink params,
    op_result_if.source result
);

    localparam int NB = opl_slot_pkg::NUM_BANKS;
    localparam int NO = opl_slot_pkg::NUM_OPERATORS_PER_BANK;
    localparam int PW = opl_slot_pkg::PHASE_WIDTH;
    localparam int OW = opl_slot_pkg::OP_OUT_WIDTH;

    logic valid_p [1:PIPELINE_DELAY];
    logic [opl_slot_pkg::BANK_NUM_WIDTH-1:0] bank_p [1:PIPELINE_DELAY];
    logic [opl_slot_pkg::OP_NUM_WIDTH-1:0] op_p [1:PIPELINE_DELAY];

    logic [PW+1:0] inc_wide;
    logic [PW-1:0] inc_1;
    logic signed [OW-1:0] mod_1;
    logic [opl_slot_pkg::FB_WIDTH-1:0] fb_1;
    logic use_fb_1;
    logic [3:0] fb_shift;
    logic signed [OW-1:0] fb_term;
    logic [PW-1:0] phase_next;

    logic [PW-1:0] phase_2;
    logic signed [OW-1:0] mod_2;
    logic signed [OW-1:0] fb_term_2;
    logic signed [OW-1:0] sum_2;
    logic signed [OW-1:0] res_p [3:PIPELINE_DELAY];

    logic [PW-1:0] phase_mem [NB][NO];
    logic signed [OW-1:0] prev_mem [NB][NO];  // last output for self-feedback

    // (fnum * mult) << block before halving
    assign inc_wide = ((PW+2)'(params.fnum) * (PW+2)'(params.mult)) << params.block;

    assign phase_next = phase_mem[bank_p[1]][op_p[1]] + inc_1;
    assign fb_shift = 4'd8 - 4'(fb_1);

    always_comb begin
        if (use_fb_1 && fb_1 != '0) begin
            fb_term = prev_mem[bank_p[1]][op_p[1]] >>> fb_shift;
        end else begin
            fb_term = '0;
        end
    end

    assign sum_2 = $signed(phase_2[PW-1 -: OW]) + mod_2 + fb_term_2;  // wraps at 13 bits

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i <= PIPELINE_DELAY; i++) begin
                valid_p[i] <= 1'b0;
            end
        end else begin
            valid_p[1] <= slot.slot_start;
            for (int i = 2; i <= PIPELINE_DELAY; i++) begin
                valid_p[i] <= valid_p[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (slot.slot_start) begin  // params valid on this cycle only
            inc_1 <= PW'(inc_wide >> 1);
            mod_1 <= params.modulation;
            fb_1 <= params.fb;
            use_fb_1 <= params.use_feedback;
        end
        bank_p[1] <= slot.bank_num;
        op_p[1] <= slot.op_num;
        for (int i = 2; i <= PIPELINE_DELAY; i++) begin
            bank_p[i] <= bank_p[i-1];
            op_p[i] <= op_p[i-1];
        end
        phase_2 <= phase_next;
        mod_2 <= mod_1;
        fb_term_2 <= fb_term;
        res_p[3] <= sum_2;
        for (int i = 4; i <= PIPELINE_DELAY; i++) begin
            res_p[i] <= res_p[i-1];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase_mem <= '{default: '0};
            prev_mem <= '{default: '0};
        end else begin
            if (valid_p[1]) phase_mem[bank_p[1]][op_p[1]] <= phase_next;
            if (valid_p[2]) prev_mem[bank_p[2]][op_p[2]] <= sum_2;
        end
    end

    assign result.result_valid = valid_p[PIPELINE_DELAY];
    assign result.result_bank = bank_p[PIPELINE_DELAY];
    assign result.result_op = op_p[PIPELINE_DELAY];
    assign result.result = res_p[PIPELINE_DELAY];

endmodule

// ==== rtl/sample_store.sv ====
// per-slot sample memory with the op-3 modulation read
// registered operator_out array and frame_done pulse

module sample_store (
    input logic clk,
    input logic rst_n,
    op_result_if.sink result,
    slot_if.monitor slot,
    output logic signed [opl_slot_pkg::OP_OUT_WIDTH-1:0] mod_sample,
    output logic signed [opl_slot_pkg::OP_OUT_WIDTH-1:0] operator_out
        [opl_slot_pkg::NUM_BANKS][opl_slot_pkg::NUM_OPERATORS_PER_BANK],
    output logic frame_done
);

    localparam int LAST_OP = opl_slot_pkg::NUM_OPERATORS_PER_BANK - 1;
    localparam int LAST_BANK = opl_slot_pkg::NUM_BANKS - 1;

    logic signed [opl_slot_pkg::OP_OUT_WIDTH-1:0] sample_mem
        [opl_slot_pkg::NUM_BANKS][opl_slot_pkg::NUM_OPERATORS_PER_BANK];
    logic last_result;

    // op-3 is always written earlier in the same frame
    assign mod_sample = (slot.op_num >= opl_slot_pkg::OP_NUM_WIDTH'(3)) ?
        sample_mem[slot.bank_num][slot.op_num - opl_slot_pkg::OP_NUM_WIDTH'(3)] : '0;

    assign last_result = result.result_valid &&
        (result.result_bank == opl_slot_pkg::BANK_NUM_WIDTH'(LAST_BANK)) &&
        (result.result_op == opl_slot_pkg::OP_NUM_WIDTH'(LAST_OP));

    always_ff @(posedge clk) begin
        if (result.result_valid) begin
            sample_mem[result.result_bank][result.result_op] <= result.result;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            operator_out <= '{default: '0};
            frame_done <= 1'b0;
        end else begin
            if (result.result_valid) begin
                operator_out[result.result_bank][result.result_op] <= result.result;
            end
            frame_done <= last_result;  // high once all 36 outputs are in place
        end
    end

endmodule

// ==== rtl/opl_slot_top.sv ====
// top level of the FM operator slot engine
// sequencer, slot timer, router, operator pipeline and sample store

module opl_slot_top #(
    parameter int PIPELINE_DELAY = 6  // cycles per slot is this plus one
) (
    input logic clk,
    input logic rst_n,
    input logic sample_clk_en,
    input logic [opl_slot_pkg::NUM_BANKS*3-1:0] connection_sel,
    input logic [opl_slot_pkg::FNUM_WIDTH-1:0] fnum
        [opl_slot_pkg::NUM_BANKS][opl_slot_pkg::NUM_CHANNELS_PER_BANK],
    input logic [opl_slot_pkg::BLOCK_WIDTH-1:0] block
        [opl_slot_pkg::NUM_BANKS][opl_slot_pkg::NUM_CHANNELS_PER_BANK],
    input logic [opl_slot_pkg::FB_WIDTH-1:0] fb
        [opl_slot_pkg::NUM_BANKS][opl_slot_pkg::NUM_CHANNELS_PER_BANK],
    input logic cnt [opl_slot_pkg::NUM_BANKS][opl_slot_pkg::NUM_CHANNELS_PER_BANK],
    input logic [opl_slot_pkg::MULT_WIDTH-1:0] mult
        [opl_slot_pkg::NUM_BANKS][opl_slot_pkg::NUM_OPERATORS_PER_BANK],
    output logic signed [opl_slot_pkg::OP_OUT_WIDTH-1:0] operator_out
        [opl_slot_pkg::NUM_BANKS][opl_slot_pkg::NUM_OPERATORS_PER_BANK],
    output logic frame_done
);

    slot_if slot_bus ();
    op_param_if param_bus ();
    op_result_if result_bus ();

    logic slot_end;
    logic signed [opl_slot_pkg::OP_OUT_WIDTH-1:0] mod_sample;  // op-3 sample

    slot_sequencer u_sequencer (
        .clk(clk),
        .rst_n(rst_n),
        .sample_clk_en(sample_clk_en),
        .slot_end(slot_end),
        .slot(slot_bus.master)
    );

    slot_timer #(.PIPELINE_DELAY(PIPELINE_DELAY)) u_timer (
        .clk(clk),
        .rst_n(rst_n),
        .slot(slot_bus.timer),
        .slot_end(slot_end)
    );

    slot_router u_router (
        .slot(slot_bus.monitor),
        .connection_sel(connection_sel),
        .fnum(fnum),
        .block(block),
        .fb(fb),
        .cnt(cnt),
        .mult(mult),
        .mod_sample(mod_sample),
        .params(param_bus.source)
    );

    operator_core #(.PIPELINE_DELAY(PIPELINE_DELAY)) u_core (
        .clk(clk),
        .rst_n(rst_n),
        .slot(slot_bus.monitor),
        .params(param_bus.sink),
        .result(result_bus.source)
    );

    sample_store u_store (
        .clk(clk),
        .rst_n(rst_n),
        .result(result_bus.sink),
        .slot(slot_bus.monitor),
        .mod_sample(mod_sample),
        .operator_out(operator_out),
        .frame_done(frame_done)
    );

endmodule

// ==== verification/tb_checker.sv ====
// reference model of the slot engine for all 36 slots
// compares operator_out on each frame_done
// checks the cleared outputs right after each reset

module tb_checker (
    input logic clk,
    input logic rst_n,
    input logic [opl_slot_pkg::NUM_BANKS*3-1:0] connection_sel,
    input logic [opl_slot_pkg::FNUM_WIDTH-1:0] fnum
        [opl_slot_pkg::NUM_BANKS][opl_slot_pkg::NUM_CHANNELS_PER_BANK],
    input logic [opl_slot_pkg::BLOCK_WIDTH-1:0] block
        [opl_slot_pkg::NUM_BANKS][opl_slot_pkg::NUM_CHANNELS_PER_BANK],
    input logic [opl_slot_pkg::FB_WIDTH-1:0] fb
        [opl_slot_pkg::NUM_BANKS][opl_slot_pkg::NUM_CHANNELS_PER_BANK],
    input logic cnt [opl_slot_pkg::NUM_BANKS][opl_slot_pkg::NUM_CHANNELS_PER_BANK],
    input logic [opl_slot_pkg::MULT_WIDTH-1:0] mult
        [opl_slot_pkg::NUM_BANKS][opl_slot_pkg::NUM_OPERATORS_PER_BANK],
    input logic signed [opl_slot_pkg::OP_OUT_WIDTH-1:0] operator_out
        [opl_slot_pkg::NUM_BANKS][opl_slot_pkg::NUM_OPERATORS_PER_BANK],
    input logic frame_done,
    output int error_count,
    output int frame_count
);

    localparam int NB = opl_slot_pkg::NUM_BANKS;
    localparam int NO = opl_slot_pkg::NUM_OPERATORS_PER_BANK;
    localparam int PW = opl_slot_pkg::PHASE_WIDTH;
    localparam int OW = opl_slot_pkg::OP_OUT_WIDTH;

    logic [PW-1:0] model_phase [NB][NO];
    logic signed [OW-1:0] model_prev [NB][NO];  // last output of each slot
    logic signed [OW-1:0] expect_out [NB][NO];
    logic rst_n_last = 1'b1;
    int errors = 0;
    int frames = 0;

    assign error_count = errors;
    assign frame_count = frames;

    // one frame of the engine in sweep order
    function automatic void model_frame();
        int ch;
        int p;
        int pos;
        logic mod_on;
        logic fb_on;
        logic [31:0] inc;
        logic signed [OW-1:0] mod_val;
        logic signed [OW-1:0] fb_val;
        for (int b = 0; b < NB; b++) begin
            for (int o = 0; o < NO; o++) begin
                p = o % 3;
                pos = o / 3;
                if (o < 12 && connection_sel[b*3 + p]) begin
                    ch = p;  // whole chain runs on channel p
                    fb_on = (pos == 0);
                    case (pos)
                        0: mod_on = 1'b0;
                        1: mod_on = !cnt[b][p];
                        2: mod_on = cnt[b][p] || !cnt[b][p+3];
                        default: mod_on = !(cnt[b][p] && cnt[b][p+3]);
                    endcase
                end else begin
                    // groups of six slots hold three modulators and then their carriers
                    ch = (o / 6) * 3 + p;
                    fb_on = (o % 6) < 3;
                    mod_on = !fb_on && !cnt[b][ch];
                end
                inc = ((32'(fnum[b][ch]) * 32'(mult[b][o])) << block[b][ch]) >> 1;
                model_phase[b][o] = model_phase[b][o] + inc[PW-1:0];
                mod_val = '0;
                if (mod_on && o >= 3) mod_val = expect_out[b][o-3];
                fb_val = '0;
                if (fb_on && fb[b][ch] != 0) begin
                    fb_val = model_prev[b][o] >>> (8 - int'(fb[b][ch]));
                end
                expect_out[b][o] = $signed(model_phase[b][o][PW-1 -: OW]) + mod_val + fb_val;
                model_prev[b][o] = expect_out[b][o];
            end
        end
    endfunction

    task automatic compare_frame();
        for (int b = 0; b < NB; b++) begin
            for (int o = 0; o < NO; o++) begin
                if (operator_out[b][o] !== expect_out[b][o]) begin
                    $display("ERR operator_out[%0d][%0d] expected %h actual %h",
                             b, o, expect_out[b][o], operator_out[b][o]);
                    errors++;
                end
            end
        end
    endtask

    task automatic check_cleared();
        for (int b = 0; b < NB; b++) begin
            for (int o = 0; o < NO; o++) begin
                if (operator_out[b][o] !== '0) begin
                    $display("ERR operator_out[%0d][%0d] expected %h actual %h",
                             b, o, 13'h0, operator_out[b][o]);
                    errors++;
                end
            end
        end
        if (frame_done !== 1'b0) begin
            $display("ERR frame_done expected 0 actual %h", frame_done);
            errors++;
        end
    endtask

    // sampled in mid-cycle while the registered outputs are stable
    always @(negedge clk) begin
        if (!rst_n) begin
            for (int b = 0; b < NB; b++) begin
                for (int o = 0; o < NO; o++) begin
                    model_phase[b][o] = '0;
                    model_prev[b][o] = '0;
                end
            end
        end else begin
            if (!rst_n_last) check_cleared();  // first cycle out of reset
            if (frame_done === 1'b1) begin
                model_frame();
                compare_frame();
                frames++;
            end
        end
        rst_n_last = rst_n;
    end

endmodule

// ==== verification/tb_top.sv ====
// testbench top level
// clock and reset, DUT instance and the stimulus of the six tests
// output values are compared in tb_checker

module tb_top;

    localparam int NB = opl_slot_pkg::NUM_BANKS;
    localparam int NC = opl_slot_pkg::NUM_CHANNELS_PER_BANK;
    localparam int NO = opl_slot_pkg::NUM_OPERATORS_PER_BANK;
    localparam int FRAME_CYCLES = 252;  // 36 slots of 7 cycles
    localparam int FRAME_TIMEOUT = 1000;  // cycles allowed for one frame

    logic clk = 1'b0;
    logic rst_n;
    logic sample_clk_en;
    logic [NB*3-1:0] connection_sel;
    logic [opl_slot_pkg::FNUM_WIDTH-1:0] fnum [NB][NC];
    logic [opl_slot_pkg::BLOCK_WIDTH-1:0] block [NB][NC];
    logic [opl_slot_pkg::FB_WIDTH-1:0] fb [NB][NC];
    logic cnt [NB][NC];
    logic [opl_slot_pkg::MULT_WIDTH-1:0] mult [NB][NO];
    logic signed [opl_slot_pkg::OP_OUT_WIDTH-1:0] operator_out [NB][NO];
    logic frame_done;

    int check_errors;
    int frames_checked;
    int tb_errors = 0;
    int errors_before = 0;
    int frames_before = 0;
    int seen;
    integer seed;

    always #20 clk = ~clk;

    opl_slot_top UUT (
        .clk(clk),
        .rst_n(rst_n),
        .sample_clk_en(sample_clk_en),
        .connection_sel(connection_sel),
        .fnum(fnum),
        .block(block),
        .fb(fb),
        .cnt(cnt),
        .mult(mult),
        .operator_out(operator_out),
        .frame_done(frame_done)
    );

    tb_checker frame_check (
        .clk(clk),
        .rst_n(rst_n),
        .connection_sel(connection_sel),
        .fnum(fnum),
        .block(block),
        .fb(fb),
        .cnt(cnt),
        .mult(mult),
        .operator_out(operator_out),
        .frame_done(frame_done),
        .error_count(check_errors),
        .frame_count(frames_checked)
    );

    // inputs change a little after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic randomize_pitch();
        for (int b = 0; b < NB; b++) begin
            for (int c = 0; c < NC; c++) begin
                fnum[b][c] = 10'($random(seed));
                block[b][c] = 3'($random(seed));
            end
            for (int o = 0; o < NO; o++) begin
                mult[b][o] = 4'($random(seed));
            end
        end
    endtask

    task automatic randomize_routing();
        connection_sel = 6'($random(seed));
        for (int b = 0; b < NB; b++) begin
            for (int c = 0; c < NC; c++) begin
                cnt[b][c] = 1'($random(seed));
            end
        end
    endtask

    task automatic clear_routing();
        connection_sel = '0;
        for (int b = 0; b < NB; b++) begin
            for (int c = 0; c < NC; c++) begin
                cnt[b][c] = 1'b0;
            end
        end
    endtask

    task automatic randomize_feedback();
        for (int b = 0; b < NB; b++) begin
            for (int c = 0; c < NC; c++) begin
                fb[b][c] = 3'({$random(seed)} % 7 + 1);  // 1 to 7
            end
        end
    endtask

    task automatic start_frame();
        sample_clk_en = 1'b1;
        next_cycle();
        sample_clk_en = 1'b0;
    endtask

    task automatic wait_frame_done();
        int cycles;
        cycles = 0;
        while (frame_done !== 1'b1 && cycles < FRAME_TIMEOUT) begin
            next_cycle();
            cycles++;
        end
        if (frame_done !== 1'b1) begin
            $display("timeout: no frame_done within %0d cycles", FRAME_TIMEOUT);
            tb_errors++;
        end
        next_cycle();  // checker compares in the frame_done cycle
    endtask

    task automatic run_frames(input int count);
        for (int i = 0; i < count; i++) begin
            start_frame();
            wait_frame_done();
        end
    endtask

    task automatic count_frame_done(input int cycles, output int count);
        count = 0;
        for (int i = 0; i < cycles; i++) begin
            next_cycle();
            if (frame_done === 1'b1) count++;
        end
    endtask

    task automatic finish_test(input int num, input string name, input int frames);
        int errs;
        if (frames_checked - frames_before != frames) begin
            $display("test %0d: checker compared %0d frames instead of %0d",
                     num, frames_checked - frames_before, frames);
            tb_errors++;
        end
        errs = check_errors + tb_errors - errors_before;
        $display("test %0d %s: %0d frames, %0d errors",
                 num, name, frames_checked - frames_before, errs);
        errors_before = check_errors + tb_errors;
        frames_before = frames_checked;
    endtask

    initial begin
        seed = 32'h14d2;
        rst_n = 1'b0;
        sample_clk_en = 1'b0;
        clear_routing();
        for (int b = 0; b < NB; b++) begin
            for (int c = 0; c < NC; c++) begin
                fnum[b][c] = '0;
                block[b][c] = '0;
                fb[b][c] = '0;
            end
            for (int o = 0; o < NO; o++) begin
                mult[b][o] = '0;
            end
        end
        repeat (5) next_cycle();
        rst_n = 1'b1;
        next_cycle();

        randomize_pitch();
        run_frames(1);
        finish_test(1, "two-operator frame", 1);

        run_frames(3);  // phases keep running on the same parameters
        finish_test(2, "repeated frames", 3);

        for (int i = 0; i < 4; i++) begin
            randomize_routing();
            run_frames(1);
        end
        finish_test(3, "four-operator routing", 4);

        clear_routing();
        for (int i = 0; i < 4; i++) begin
            randomize_feedback();
            run_frames(1);
        end
        finish_test(4, "self-feedback", 4);

        start_frame();
        repeat (100) next_cycle();
        sample_clk_en = 1'b1;  // arrives while the sweep runs
        next_cycle();
        sample_clk_en = 1'b0;
        // long enough to see a second frame started by the ignored pulse
        count_frame_done(2 * FRAME_CYCLES, seen);
        if (seen != 1) begin
            $display("test 5: %0d frame_done pulses after one started frame", seen);
            tb_errors++;
        end
        run_frames(1);
        finish_test(5, "start pulse during a frame", 2);

        start_frame();
        repeat (100) next_cycle();
        rst_n = 1'b0;
        repeat (5) next_cycle();
        rst_n = 1'b1;
        repeat (3) next_cycle();
        run_frames(1);
        finish_test(6, "reset during a frame", 1);

        $display("tests 6, frames %0d, errors %0d", frames_checked, check_errors + tb_errors);
        if (check_errors + tb_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== opl_slot.f ====
rtl/opl_slot_pkg.sv
rtl/slot_if.sv
rtl/slot_sequencer.sv
rtl/slot_timer.sv
rtl/slot_router.sv
rtl/operator_core.sv
rtl/sample_store.sv
rtl/opl_slot_top.sv
verification/tb_checker.sv
verification/tb_top.sv

// ==== Makefile ====
# Verilator simulation of the slot engine testbench

VERILATOR ?= verilator
TOP ?= tb_top
FILELIST ?= opl_slot.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qF '*** PASSED ***' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
